// ==== Makefile ====
# Verilator simulation of the GCM GHASH tag engine.

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_gcm_ghash_tag
FILELIST  = gcm_ghash_tag.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^Result: PASSED$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== gcm_ghash_tag.f ====
gcm_params_pkg.sv
gcm_types_pkg.sv
ghash_block_if.sv
ghash_sequencer.sv
gf128_multiplier.sv
ghash_accumulator.sv
gcm_tag_output.sv
gcm_ghash_tag.sv
gcm_ghash_tag_sva.sv
tb_tag_checker.sv
tb_gcm_ghash_tag.sv

// ==== gcm_ghash_tag.sv ====
// ===================================================================
// GCM GHASH tag engine top: sequencer, accumulator and tag output.
// ===================================================================
`timescale 1ns/100ps

module gcm_ghash_tag (
    input  logic                                  i_clock,
    input  logic                                  i_reset,
    input  logic                                  i_sop,           // Start of frame.
    input  logic                                  i_valid_text,    // Text block strobe.
    input  gcm_types_pkg::block_t                 i_text_block,
    input  gcm_types_pkg::block_t                 i_aad,
    input  gcm_types_pkg::block_t                 i_hash_subkey,   // H.
    input  logic [gcm_params_pkg::NB_LENGTH-1:0]  i_length_aad,
    input  logic [gcm_params_pkg::NB_LENGTH-1:0]  i_length_text,
    input  gcm_types_pkg::block_t                 i_enc_j0,        // E(K, J0).
    input  logic                                  i_clear_fault,
    output gcm_types_pkg::block_t                 o_tag,
    output logic                                  o_tag_valid,
    output logic                                  o_fault_sop_busy
);

    gcm_types_pkg::block_t  hash;               // Running GHASH.
    logic                   hash_done;          // Final GHASH strobe.

    // Block strobes between the stages.
    ghash_block_if blk_if ();

    // ===================================================================
    // Stages.
    // ===================================================================
    ghash_sequencer ghash_sequencer_i (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_sop            (i_sop),
        .i_valid_text     (i_valid_text),
        .i_text_block     (i_text_block),
        .i_aad            (i_aad),
        .i_hash_subkey    (i_hash_subkey),
        .i_length_aad     (i_length_aad),
        .i_length_text    (i_length_text),
        .i_clear_fault    (i_clear_fault),
        .o_fault_sop_busy (o_fault_sop_busy),
        .blk              (blk_if)
    );

    ghash_accumulator ghash_accumulator_i (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .blk     (blk_if),
        .o_hash  (hash),
        .o_done  (hash_done)
    );

    gcm_tag_output gcm_tag_output_i (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_enc_j0    (i_enc_j0),
        .i_hash      (hash),
        .i_done      (hash_done),
        .blk         (blk_if),
        .o_tag       (o_tag),
        .o_tag_valid (o_tag_valid)
    );

endmodule

// ==== gcm_ghash_tag_sva.sv ====
// ======================================================================
// Assertions on tag strobe width, tag latency and fault flag hold.
// ======================================================================
`timescale 1ns/100ps

module gcm_ghash_tag_sva (
    input logic                                  i_clock,
    input logic                                  i_reset,
    input logic                                  i_sop,
    input logic                                  i_valid_text,
    input logic [gcm_params_pkg::NB_LENGTH-1:0]  i_length_text,
    input logic                                  i_clear_fault,
    input logic                                  i_tag_valid,
    input logic                                  i_fault_sop_busy
);

    logic [gcm_params_pkg::NB_BLOCK_COUNT-1:0]  frame_blocks;
    logic [gcm_params_pkg::NB_BLOCK_COUNT-1:0]  blocks_left;   // Text still due.
    logic                                       in_text;
    logic                                       in_length;     // Length word cycle.
    logic                                       frame_end;     // Last input of the frame.

    assign frame_blocks = i_length_text[gcm_params_pkg::LOG2_NB_BLOCK +: gcm_params_pkg::NB_BLOCK_COUNT];
    assign frame_end = (!in_text && !in_length && i_sop && frame_blocks == '0)
                    || (in_text && i_valid_text && blocks_left == 12'd1);

    // Frame tracker, from the port protocol.
    always_ff @(posedge i_clock)
    begin : l_track
        if (i_reset)
        begin
            in_text     <= 1'b0;
            in_length   <= 1'b0;
            blocks_left <= '0;
        end
        else
        begin
            in_length <= 1'b0;
            if (!in_text && !in_length && i_sop)
            begin
                blocks_left <= frame_blocks;
                in_text     <= (frame_blocks != '0);
                in_length   <= (frame_blocks == '0);   // Empty text.
            end
            else if (in_text && i_valid_text)
            begin
                blocks_left <= blocks_left - 12'd1;
                if (blocks_left == 12'd1)
                begin
                    in_text   <= 1'b0;
                    in_length <= 1'b1;
                end
            end
        end
    end

    a_tag_one_cycle : assert property (@(posedge i_clock) disable iff (i_reset)
        i_tag_valid |=> !i_tag_valid)
        else $error("o_tag_valid wider than one cycle");

    // Rises on the fourth edge after the sample, seen on the fifth.
    a_tag_latency : assert property (@(posedge i_clock) disable iff (i_reset)
        frame_end |-> ##5 i_tag_valid)
        else $error("o_tag_valid not four cycles after the last frame input");

    a_fault_hold : assert property (@(posedge i_clock) disable iff (i_reset)
        i_fault_sop_busy && !i_clear_fault |=> i_fault_sop_busy)
        else $error("o_fault_sop_busy dropped without i_clear_fault");

endmodule

// ==== gcm_params_pkg.sv ====
// ===================================================================
// Widths and constants of the GHASH tag datapath.
// ===================================================================

package gcm_params_pkg;

    // ===================================================================
    // Block and length fields.
    // ===================================================================
    localparam int NB_BLOCK       = 128;     // One GCM block.
    localparam int NB_LENGTH      = 64;      // Each half of the length word.
    localparam int LOG2_NB_BLOCK  = 7;       // Bits to blocks shift.

    // Text block counter, up to 4095 blocks per frame.
    localparam int NB_BLOCK_COUNT = 12;

    // ===================================================================
    // GF(2^128) reduction.
    // ===================================================================
    // R = 11100001 || 0^120, bit 127 of the vector is x^0.
    localparam logic [NB_BLOCK-1:0] GF_REDUCTION = {
        8'hE1,
        {(NB_BLOCK - 8){1'b0}}
    };

endpackage

// ==== gcm_tag_output.sv ====
// ===================================================================
// Tag output: E(K, J0) lock, tag register and tag strobe.
// ===================================================================
`timescale 1ns/100ps

module gcm_tag_output (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  gcm_types_pkg::block_t  i_enc_j0,    // E(K, J0) of the frame.
    input  gcm_types_pkg::block_t  i_hash,      // Final GHASH value.
    input  logic                   i_done,
    ghash_block_if.monitor         blk,
    output gcm_types_pkg::block_t  o_tag,
    output logic                   o_tag_valid
);

    gcm_types_pkg::block_t  enc_j0_q;

    // Captured as the frame's AAD block goes through.
    always_ff @(posedge i_clock)
    begin : l_lock_j0
        if (blk.strobe && (blk.kind == gcm_types_pkg::BLK_AAD))
            enc_j0_q <= i_enc_j0;
    end

    // T = E(K, J0) xor GHASH, held until the next frame's tag.
    always_ff @(posedge i_clock)
    begin : l_tag
        if (i_reset)
        begin
            o_tag       <= '0;
            o_tag_valid <= 1'b0;
        end
        else
        begin
            o_tag_valid <= i_done;                      // Single-cycle strobe.
            if (i_done)
                o_tag <= i_hash ^ enc_j0_q;
        end
    end

endmodule

// ==== gcm_types_pkg.sv ====
// ===================================================================
// Block type, sequencer states and block kinds.
// ===================================================================

package gcm_types_pkg;

    // All blocks, hash values and tags.
    typedef logic [gcm_params_pkg::NB_BLOCK-1:0] block_t;

    // Sequencer FSM states.
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,                   // Waiting for start of frame.
        ST_TEXT   = 2'd1,                   // Taking text blocks.
        ST_LENGTH = 2'd2                    // Emitting the length word.
    } seq_state_e;

    // Kind of block carried on the block strobe.
    typedef enum logic [1:0] {
        BLK_AAD    = 2'd0,                  // Restarts the hash.
        BLK_TEXT   = 2'd1,
        BLK_LENGTH = 2'd2                   // Last block of a frame.
    } block_kind_e;

endpackage

// ==== gf128_multiplier.sv ====
// ===================================================================
// Combinational GF(2^128) multiplier in GCM bit order.
// ===================================================================
`timescale 1ns/100ps

module gf128_multiplier (
    input  gcm_types_pkg::block_t  i_x,
    input  gcm_types_pkg::block_t  i_h,
    output gcm_types_pkg::block_t  o_product
);

    // Shift-and-add over all 128 bits of X, unrolled into logic.
    // The MSB of each vector is the x^0 coefficient.
    always_comb
    begin : l_multiply
        gcm_types_pkg::block_t z;                      // Partial product.
        gcm_types_pkg::block_t v;                      // H times x^i.
        z = '0;
        v = i_h;
        for (int i = 0; i < gcm_params_pkg::NB_BLOCK; i++)
        begin
            // Coefficient of x^i set, add the current V.
            if (i_x[gcm_params_pkg::NB_BLOCK-1-i])
                z = z ^ v;
            // Multiply V by x, reduce when x^127 falls out.
            if (v[0])
                v = (v >> 1) ^ gcm_params_pkg::GF_REDUCTION;
            else
                v = v >> 1;
        end
        o_product = z;
    end

endmodule

// ==== ghash_accumulator.sv ====
// ===================================================================
// GHASH accumulator: running hash update and end of frame strobe.
// ===================================================================
`timescale 1ns/100ps

module ghash_accumulator (
    input  logic                   i_clock,
    input  logic                   i_reset,
    ghash_block_if.sink            blk,
    output gcm_types_pkg::block_t  o_hash,      // Running hash Y.
    output logic                   o_done       // Y final, one cycle.
);

    gcm_types_pkg::block_t  hash_q;
    gcm_types_pkg::block_t  mult_x;
    gcm_types_pkg::block_t  product;

    // AAD starts a new frame, so the previous hash is dropped.
    always_comb
    begin : l_mult_in
        if (blk.kind == gcm_types_pkg::BLK_AAD)
            mult_x = blk.block;
        else
            mult_x = blk.block ^ hash_q;
    end

    gf128_multiplier u_gf128_multiplier (
        .i_x       (mult_x),
        .i_h       (blk.hash_subkey),
        .o_product (product)
    );

    // Y = (Y xor X) * H on each block strobe.
    always_ff @(posedge i_clock)
    begin : l_hash
        if (blk.strobe)
            hash_q <= product;
    end

    // Length block absorbed, hash is final.
    always_ff @(posedge i_clock)
    begin : l_done
        if (i_reset)
            o_done <= 1'b0;
        else
            o_done <= blk.strobe && (blk.kind == gcm_types_pkg::BLK_LENGTH);
    end

    assign o_hash = hash_q;

endmodule

// ==== ghash_block_if.sv ====
// ===================================================================
// Block strobe bus from the sequencer to the GHASH accumulator.
// ===================================================================
`timescale 1ns/100ps

interface ghash_block_if;

    logic                        strobe;       // One cycle, block valid.
    gcm_types_pkg::block_kind_e  kind;         // AAD, text or length.
    gcm_types_pkg::block_t       block;        // Block to absorb.
    gcm_types_pkg::block_t       hash_subkey;  // H, locked per frame.

    // Sequencer side.
    modport source (
        output strobe, kind, block, hash_subkey
    );

    // Accumulator side, absorbs every strobe.
    modport sink (
        input strobe, kind, block, hash_subkey
    );

    // Tag output only follows frame boundaries.
    modport monitor (
        input strobe, kind
    );

endinterface

// ==== ghash_sequencer.sv ====
// ===================================================================
// GHASH input sequencer: frame locking, text block count, AAD, text
// and length block strobes, sticky busy fault.
// ===================================================================
`timescale 1ns/100ps

module ghash_sequencer (
    input  logic                                  i_clock,
    input  logic                                  i_reset,
    input  logic                                  i_sop,           // Start of frame.
    input  logic                                  i_valid_text,    // Text block strobe.
    input  gcm_types_pkg::block_t                 i_text_block,
    input  gcm_types_pkg::block_t                 i_aad,
    input  gcm_types_pkg::block_t                 i_hash_subkey,
    input  logic [gcm_params_pkg::NB_LENGTH-1:0]  i_length_aad,    // In bits.
    input  logic [gcm_params_pkg::NB_LENGTH-1:0]  i_length_text,   // In bits.
    input  logic                                  i_clear_fault,
    output logic                                  o_fault_sop_busy,
    ghash_block_if.source                         blk
);

    gcm_types_pkg::seq_state_e                    state;
    logic [gcm_params_pkg::NB_BLOCK_COUNT-1:0]    remaining;       // Text blocks still due.
    logic [gcm_params_pkg::NB_BLOCK_COUNT-1:0]    remaining_next;
    logic [gcm_params_pkg::NB_BLOCK_COUNT-1:0]    text_count;
    logic [gcm_params_pkg::NB_LENGTH-1:0]         length_aad_q;
    logic [gcm_params_pkg::NB_LENGTH-1:0]         length_text_q;
    gcm_types_pkg::block_t                        hash_subkey_q;
    logic                                         sop_accept;
    logic                                         text_accept;
    logic                                         emit_strobe;     // First stage of the strobe.
    gcm_types_pkg::block_kind_e                   emit_kind;
    gcm_types_pkg::block_t                        emit_block;

    // Whole text blocks in the frame, partial blocks are not supported.
    assign text_count = i_length_text[gcm_params_pkg::LOG2_NB_BLOCK +: gcm_params_pkg::NB_BLOCK_COUNT];
    assign remaining_next = remaining - 1'b1;
    assign sop_accept  = i_sop && (state == gcm_types_pkg::ST_IDLE);
    assign text_accept = i_valid_text && (state == gcm_types_pkg::ST_TEXT);

    // ===================================================================
    // Frame FSM.
    // ===================================================================
    always_ff @(posedge i_clock)
    begin : l_fsm
        if (i_reset)
        begin
            state     <= gcm_types_pkg::ST_IDLE;
            remaining <= '0;
        end
        else
        begin
            case (state)
                gcm_types_pkg::ST_IDLE:
                    if (i_sop)
                    begin
                        remaining <= text_count;
                        if (text_count == '0)
                            state <= gcm_types_pkg::ST_LENGTH;   // Empty text.
                        else
                            state <= gcm_types_pkg::ST_TEXT;
                    end
                gcm_types_pkg::ST_TEXT:
                    if (i_valid_text)
                    begin
                        remaining <= remaining_next;
                        if (remaining_next == '0)
                            state <= gcm_types_pkg::ST_LENGTH;   // Last text block taken.
                    end
                default:
                    state <= gcm_types_pkg::ST_IDLE;             // Length goes out once.
            endcase
        end
    end

    // Frame-static inputs, held until the next accepted start.
    always_ff @(posedge i_clock)
    begin : l_lock_frame
        if (sop_accept)
        begin
            length_aad_q  <= i_length_aad;
            length_text_q <= i_length_text;
            hash_subkey_q <= i_hash_subkey;
        end
    end

    // ===================================================================
    // Block emission, two register stages.
    // ===================================================================
    always_ff @(posedge i_clock)
    begin : l_emit_strobe
        if (i_reset)
        begin
            emit_strobe <= 1'b0;
            blk.strobe  <= 1'b0;
        end
        else
        begin
            emit_strobe <= sop_accept || text_accept || (state == gcm_types_pkg::ST_LENGTH);
            blk.strobe  <= emit_strobe;
        end
    end

    always_ff @(posedge i_clock)
    begin : l_emit_block
        if (sop_accept)
        begin
            emit_kind  <= gcm_types_pkg::BLK_AAD;
            emit_block <= i_aad;                       // Single AAD block.
        end
        else if (text_accept)
        begin
            emit_kind  <= gcm_types_pkg::BLK_TEXT;
            emit_block <= i_text_block;
        end
        else if (state == gcm_types_pkg::ST_LENGTH)
        begin
            emit_kind  <= gcm_types_pkg::BLK_LENGTH;
            emit_block <= {length_aad_q, length_text_q};   // len(A) || len(C).
        end
        blk.kind  <= emit_kind;
        blk.block <= emit_block;
    end

    assign blk.hash_subkey = hash_subkey_q;

    // Sticky fault, a start while a frame is still running.
    always_ff @(posedge i_clock)
    begin : l_fault
        if (i_reset)
            o_fault_sop_busy <= 1'b0;
        else if (i_sop && (state != gcm_types_pkg::ST_IDLE))
            o_fault_sop_busy <= 1'b1;
        else if (i_clear_fault)
            o_fault_sop_busy <= 1'b0;
    end

endmodule

// ==== tb_gcm_ghash_tag.sv ====
// ======================================================================
// Testbench top: clock, reset, LFSR stimulus, GHASH reference model,
// watchdog and test summary.
// ======================================================================
`timescale 1ns/100ps

module tb_gcm_ghash_tag;

    localparam int PERIOD           = 100;                  // Clock period in ns.
    localparam int RESET_CYCLES     = 16;
    localparam int TAG_LATENCY      = 4;                    // Last sample to tag strobe.
    localparam int TAG_WAIT_LIMIT   = 20;
    localparam int NUM_FRAMES       = 18;                   // Frames over all tests.
    localparam int MAX_FRAME_CYCLES = 32;                   // Six blocks, gaps of three.
    localparam int WATCHDOG_CYCLES  = RESET_CYCLES + NUM_FRAMES * MAX_FRAME_CYCLES + 100;

    logic                                  clock = 1'b0;
    logic                                  reset;
    logic                                  sop;
    logic                                  valid_text;
    gcm_types_pkg::block_t                 text_block;
    gcm_types_pkg::block_t                 aad;
    gcm_types_pkg::block_t                 hash_subkey;
    logic [gcm_params_pkg::NB_LENGTH-1:0]  length_aad;
    logic [gcm_params_pkg::NB_LENGTH-1:0]  length_text;
    gcm_types_pkg::block_t                 enc_j0;
    logic                                  clear_fault;
    gcm_types_pkg::block_t                 tag;
    logic                                  tag_valid;
    logic                                  fault_sop_busy;

    logic                                  push_tag;        // Hands one tag to the checker.
    gcm_types_pkg::block_t                 expected_tag;
    logic                                  expected_fault;
    int                                    checker_errors;
    int                                    pending;

    logic [31:0]                           lfsr_state = 32'd27;
    gcm_types_pkg::block_t                 text_blocks[$];  // Text of the current frame.
    int                                    tb_errors = 0;
    int                                    errors_at_start = 0;
    int                                    test_number = 0;
    int                                    pass_count = 0;
    int                                    fail_count = 0;

    always #(PERIOD / 2) clock = ~clock;

    // ======================================================================
    // DUT, checker and assertions.
    // ======================================================================
    gcm_ghash_tag gcm_ghash_tag_i (
        .i_clock          (clock),
        .i_reset          (reset),
        .i_sop            (sop),
        .i_valid_text     (valid_text),
        .i_text_block     (text_block),
        .i_aad            (aad),
        .i_hash_subkey    (hash_subkey),
        .i_length_aad     (length_aad),
        .i_length_text    (length_text),
        .i_enc_j0         (enc_j0),
        .i_clear_fault    (clear_fault),
        .o_tag            (tag),
        .o_tag_valid      (tag_valid),
        .o_fault_sop_busy (fault_sop_busy)
    );

    tb_tag_checker tb_tag_checker_i (
        .i_clock          (clock),
        .i_reset          (reset),
        .i_tag            (tag),
        .i_tag_valid      (tag_valid),
        .i_fault_sop_busy (fault_sop_busy),
        .i_push_tag       (push_tag),
        .i_expected_tag   (expected_tag),
        .i_expected_fault (expected_fault),
        .o_error_count    (checker_errors),
        .o_pending        (pending)
    );

    bind gcm_ghash_tag gcm_ghash_tag_sva gcm_ghash_tag_sva_i (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_sop            (i_sop),
        .i_valid_text     (i_valid_text),
        .i_length_text    (i_length_text),
        .i_clear_fault    (i_clear_fault),
        .i_tag_valid      (o_tag_valid),
        .i_fault_sop_busy (o_fault_sop_busy)
    );

    // ======================================================================
    // Random numbers and reference model.
    // ======================================================================
    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR step per bit, first bit ends up most significant.
    function automatic gcm_types_pkg::block_t random_value(input int n_bits);
        gcm_types_pkg::block_t value;
        value = '0;
        for (int i = 0; i < n_bits; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[gcm_params_pkg::NB_BLOCK-2:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Horner form, highest degree first. Bit j holds the x^(127-j) term.
    function automatic gcm_types_pkg::block_t gf_multiply(
        input gcm_types_pkg::block_t y,
        input gcm_types_pkg::block_t h
    );
        gcm_types_pkg::block_t z;
        z = '0;
        for (int j = 0; j < gcm_params_pkg::NB_BLOCK; j++)
        begin
            if (z[0])
                z = (z >> 1) ^ gcm_params_pkg::GF_REDUCTION;    // Times x, reduced.
            else
                z = z >> 1;
            if (y[j])
                z = z ^ h;
        end
        return z;
    endfunction

    // GHASH over AAD, text and length word, then masked with E(K, J0).
    task automatic compute_tag(output gcm_types_pkg::block_t result);
        gcm_types_pkg::block_t y;
        y = gf_multiply(aad, hash_subkey);
        foreach (text_blocks[i])
            y = gf_multiply(y ^ text_blocks[i], hash_subkey);
        y = gf_multiply(y ^ {length_aad, length_text}, hash_subkey);
        result = y ^ enc_j0;
    endtask

    // ======================================================================
    // Frame driver and bookkeeping.
    // ======================================================================
    task automatic send_frame(input int n_blocks, input int max_gap, input bit busy_sop);
        gcm_types_pkg::block_t expected;
        int                    gap;
        int                    cycles;
        text_blocks.delete();
        for (int i = 0; i < n_blocks; i++)
            text_blocks.push_back(random_value(gcm_params_pkg::NB_BLOCK));
        hash_subkey = random_value(gcm_params_pkg::NB_BLOCK);
        aad         = random_value(gcm_params_pkg::NB_BLOCK);
        enc_j0      = random_value(gcm_params_pkg::NB_BLOCK);
        length_aad  = 64'd128;                                   // One full AAD block.
        length_text = 64'(n_blocks) << gcm_params_pkg::LOG2_NB_BLOCK;
        compute_tag(expected);
        sop = 1'b1;
        @(negedge clock);
        sop = 1'b0;
        // New frame inputs after the start must not reach the tag.
        aad         = random_value(gcm_params_pkg::NB_BLOCK);
        hash_subkey = random_value(gcm_params_pkg::NB_BLOCK);
        length_aad  = 64'(random_value(gcm_params_pkg::NB_LENGTH));
        length_text = 64'(random_value(gcm_params_pkg::NB_LENGTH));
        if (busy_sop)
        begin
            sop = 1'b1;                                          // Frame is in TEXT here.
            @(negedge clock);
            sop = 1'b0;
            expected_fault = 1'b1;
        end
        foreach (text_blocks[i])
        begin
            gap = int'(random_value(2)) % (max_gap + 1);
            repeat (gap) @(negedge clock);
            valid_text = 1'b1;
            text_block = text_blocks[i];
            @(negedge clock);
            valid_text = 1'b0;
        end
        push_tag     = 1'b1;
        expected_tag = expected;
        @(negedge clock);
        push_tag = 1'b0;
        cycles   = 1;                                            // One edge since the last sample.
        while (!tag_valid && cycles < TAG_WAIT_LIMIT)
        begin
            @(negedge clock);
            cycles++;
            if (cycles == 2)
                enc_j0 = random_value(gcm_params_pkg::NB_BLOCK); // Locked at the AAD strobe.
        end
        if (!tag_valid)
        begin
            tb_errors++;
            $display("No tag strobe within %0d cycles of the last sample at %0t", cycles, $time);
        end
        else if (cycles != TAG_LATENCY)
        begin
            tb_errors++;
            $display("Tag strobe came %0d cycles after the last sample instead of %0d at %0t",
                     cycles, TAG_LATENCY, $time);
        end
    endtask

    task automatic finish_test(input string name);
        int errors;
        errors = tb_errors + checker_errors;
        test_number++;
        if (errors == errors_at_start)
        begin
            pass_count++;
            $display("Test %0d %s: pass", test_number, name);
        end
        else
        begin
            fail_count++;
            $display("Test %0d %s: FAIL, %0d errors", test_number, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // ======================================================================
    // Test sequence.
    // ======================================================================
    initial
    begin : l_main
        reset          = 1'b1;
        sop            = 1'b0;
        valid_text     = 1'b0;
        text_block     = '0;
        aad            = '0;
        hash_subkey    = '0;
        length_aad     = '0;
        length_text    = '0;
        enc_j0         = '0;
        clear_fault    = 1'b0;
        push_tag       = 1'b0;
        expected_tag   = '0;
        expected_fault = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        for (int i = 0; i < 5; i++)
            send_frame(1 + int'(random_value(3)) % 6, 0, 1'b0);
        finish_test("single frames with 1 to 6 text blocks");

        send_frame(0, 0, 1'b0);
        finish_test("empty text");

        for (int i = 0; i < 10; i++)
            send_frame(1 + int'(random_value(3)) % 6, 3, 1'b0);
        finish_test("back-to-back frames with gaps");

        send_frame(3, 1, 1'b1);
        finish_test("start of frame while busy");

        repeat (4) @(negedge clock);                             // Flag must stay set.
        clear_fault = 1'b1;
        @(negedge clock);
        clear_fault    = 1'b0;
        expected_fault = 1'b0;
        repeat (3) @(negedge clock);
        finish_test("fault held until cleared");

        repeat (5)
        begin
            valid_text = 1'b1;                                   // No frame is running.
            text_block = random_value(gcm_params_pkg::NB_BLOCK);
            @(negedge clock);
        end
        valid_text = 1'b0;
        repeat (3) @(negedge clock);
        send_frame(2, 1, 1'b0);
        finish_test("text strobes outside a frame");

        repeat (4) @(negedge clock);
        if (pending != 0)
        begin
            tb_errors++;
            $display("%0d expected tags never arrived", pending);
        end
        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 pass_count, fail_count, tb_errors + checker_errors);
        if (fail_count == 0 && tb_errors + checker_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // Ends a hung run.
    initial
    begin : l_watchdog
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== tb_tag_checker.sv ====
// ======================================================================
// Tag and fault flag checker against the testbench model.
// ======================================================================
`timescale 1ns/100ps

module tb_tag_checker (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  gcm_types_pkg::block_t  i_tag,
    input  logic                   i_tag_valid,
    input  logic                   i_fault_sop_busy,
    input  logic                   i_push_tag,          // Queue one expected tag.
    input  gcm_types_pkg::block_t  i_expected_tag,
    input  logic                   i_expected_fault,
    output int                     o_error_count,
    output int                     o_pending            // Tags still due.
);

    gcm_types_pkg::block_t  expected_q[$];
    gcm_types_pkg::block_t  expected;
    logic                   tag_valid_q = 1'b0;
    int                     error_count = 0;

    assign o_error_count = error_count;

    // Values are read at the rising edge, before the DUT updates them.
    always @(posedge i_clock)
    begin : l_check
        if (i_reset)
            tag_valid_q = 1'b0;
        else
        begin
            if (i_push_tag)
                expected_q.push_back(i_expected_tag);
            if (i_tag_valid && tag_valid_q)
            begin
                error_count++;
                $display("o_tag_valid high for more than one cycle at %0t", $time);
            end
            if (i_tag_valid && expected_q.size() == 0)
            begin
                error_count++;
                $display("Unexpected o_tag_valid at %0t with no tag outstanding", $time);
            end
            else if (i_tag_valid)
            begin
                expected = expected_q.pop_front();            // Tags come in frame order.
                if (i_tag !== expected)
                begin
                    error_count++;
                    $display("Mismatch at %0t: o_tag expected %h, got %h", $time, expected, i_tag);
                end
            end
            if (i_fault_sop_busy !== i_expected_fault)
            begin
                error_count++;
                $display("Mismatch at %0t: o_fault_sop_busy expected %b, got %b",
                         $time, i_expected_fault, i_fault_sop_busy);
            end
            tag_valid_q = i_tag_valid;
        end
        o_pending = expected_q.size();
    end

endmodule
